// ==== include/modexp_ref.svh ====
/* reference model functions for the testbench, built on modexp_pkg types
   plain wide arithmetic, slow but exact */
`ifndef MODEXP_REF_SVH
`define MODEXP_REF_SVH

// wide enough for a full product of two operands
typedef logic [2*$bits(modexp_pkg::operand_t)-1:0] ref_wide_t;

// -n0^-1 mod 2^w by Newton iteration, n0 must be odd
function automatic modexp_pkg::word_t ref_nprime0(input modexp_pkg::word_t n0);
    modexp_pkg::word_t inv;
    inv = n0;                           // correct to 3 bits for odd n0
    for (int i = 0; i < 5; i++) begin
        inv = inv * (modexp_pkg::word_t'(2) - n0 * inv);   // doubles the correct bits
    end
    return modexp_pkg::word_t'(0) - inv;
endfunction

// R mod n and R^2 mod n, with R = 2^(NUM_WORDS*WORD_WIDTH)
function automatic void ref_mont_consts(input  modexp_pkg::operand_t n,
                                        output modexp_pkg::operand_t r_mod,
                                        output modexp_pkg::operand_t t_mod);
    ref_wide_t n_w;
    ref_wide_t r_w;
    n_w   = n;
    r_w   = (ref_wide_t'(1) << $bits(modexp_pkg::operand_t)) % n_w;
    r_mod = r_w[$bits(modexp_pkg::operand_t)-1:0];
    r_w   = (r_w * r_w) % n_w;
    t_mod = r_w[$bits(modexp_pkg::operand_t)-1:0];
endfunction

// m^e mod n by plain left-to-right square-and-multiply
function automatic modexp_pkg::operand_t ref_modexp(input modexp_pkg::operand_t m,
                                                    input modexp_pkg::operand_t e,
                                                    input modexp_pkg::operand_t n);
    ref_wide_t                                 n_w;
    ref_wide_t                                 base;
    ref_wide_t                                 res;
    logic [$bits(modexp_pkg::operand_t)-1:0]   e_flat;
    n_w    = n;
    base   = m;
    base   = base % n_w;
    res    = 1;
    e_flat = e;
    for (int i = $bits(modexp_pkg::operand_t) - 1; i >= 0; i--) begin
        res = (res * res) % n_w;
        if (e_flat[i]) begin
            res = (res * base) % n_w;
        end
    end
    return res[$bits(modexp_pkg::operand_t)-1:0];
endfunction

`endif

// ==== dv/modexp_tb.sv ====
/* directed tests for modexp_top against the wide-arithmetic reference model
   operands obey the DUT limits: odd n below R/4, 0 < m < n, nonzero e */
`timescale 1ns/1ps

module modexp_tb import modexp_pkg::*; ();

    `include "modexp_ref.svh"

    localparam int          OP_BITS         = $bits(operand_t);
    localparam int unsigned RAND_SEED       = 32'he8e4d256;
    localparam int          SHORT_TIMEOUT   = 20;
    localparam int          COMPUTE_TIMEOUT = 40000;  // 258 products worst case

    logic       clk;
    logic       reset;
    logic       start_input;
    logic       start_compute;
    logic       get_result;
    load_word_t load_words;
    word_t      nprime0;
    exp_phase_t phase;
    word_t      result_word;

    modexp_top UUT (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .load_words    (load_words),
        .nprime0       (nprime0),
        .phase         (phase),
        .result_word   (result_word)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [OP_BITS-1:0] actual,
                               input logic [OP_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_for_phase(input exp_phase_t target, input int limit,
                                  input string what);
        int cycles;
        cycles = 0;
        while (phase != target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (phase != target) begin
            $display("Timeout: the DUT did not reach %s within %0d cycles", what, limit);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    endtask

    task automatic load_operands(input operand_t m_in, input operand_t e_in,
                                 input operand_t n_in, input operand_t r_in,
                                 input operand_t t_in);
        start_input = 1'b1;
        @(negedge clk);
        start_input = 1'b0;
        check_value("phase after start_input", OP_BITS'(phase), OP_BITS'(PH_LOAD));
        for (int k = 0; k < NUM_WORDS; k++) begin
            load_words.m = m_in[k];
            load_words.e = e_in[k];
            load_words.n = n_in[k];
            load_words.r = r_in[k];
            load_words.t = t_in[k];
            @(negedge clk);
        end
        load_words = '0;
    endtask

    task automatic run_compute();
        wait_for_phase(PH_WAIT_COMPUTE, SHORT_TIMEOUT, "PH_WAIT_COMPUTE");
        start_compute = 1'b1;
        @(negedge clk);
        start_compute = 1'b0;
        check_value("phase after start_compute", OP_BITS'(phase), OP_BITS'(PH_TO_MONT));
        wait_for_phase(PH_COMPLETE, COMPUTE_TIMEOUT, "PH_COMPLETE");
    endtask

    // readout must run on consecutive cycles, then terminal, then idle
    task automatic read_result(output operand_t res);
        get_result = 1'b1;
        @(negedge clk);
        get_result = 1'b0;
        for (int k = 0; k < NUM_WORDS; k++) begin
            check_value("phase during readout", OP_BITS'(phase), OP_BITS'(PH_UNLOAD));
            res[k] = result_word;
            @(negedge clk);
        end
        check_value("phase after readout", OP_BITS'(phase), OP_BITS'(PH_TERMINAL));
        check_value("result_word in terminal", OP_BITS'(result_word), '0);
        @(negedge clk);
        check_value("phase after terminal", OP_BITS'(phase), OP_BITS'(PH_IDLE));
    endtask

    task automatic run_case(input string label, input operand_t m_in, input operand_t e_in,
                            input operand_t n_in, output operand_t got);
        operand_t r_val;
        operand_t t_val;
        operand_t expected;
        ref_mont_consts(n_in, r_val, t_val);
        expected = ref_modexp(m_in, e_in, n_in);
        wait_for_phase(PH_IDLE, SHORT_TIMEOUT, "PH_IDLE");
        nprime0 = ref_nprime0(n_in[0]);   // level, stable until the next case
        load_operands(m_in, e_in, n_in, r_val, t_val);
        run_compute();
        read_result(got);
        check_value({label, " result"}, got, expected);
    endtask

    function automatic operand_t random_operand();
        operand_t val;
        for (int k = 0; k < NUM_WORDS; k++) begin
            val[k] = $urandom();
        end
        return val;
    endfunction

    function automatic operand_t random_modulus();
        operand_t val;
        val = random_operand();
        val[NUM_WORDS-1] = (val[NUM_WORDS-1] & 32'h3fff_ffff) | 32'h0000_0100;  // below R/4
        val[0] = val[0] | 32'h1;                                                 // odd
        return val;
    endfunction

    function automatic operand_t random_base(input operand_t n_in);
        operand_t val;
        val = operand_t'(random_operand() % n_in);
        if (val == '0) begin
            val = operand_t'(1);
        end
        return val;
    endfunction

    task automatic test_idle_strobes();
        check_value("phase after reset", OP_BITS'(phase), OP_BITS'(PH_IDLE));
        check_value("result_word after reset", OP_BITS'(result_word), '0);
        start_compute = 1'b1;
        @(negedge clk);
        start_compute = 1'b0;
        check_value("phase after idle start_compute", OP_BITS'(phase), OP_BITS'(PH_IDLE));
        get_result = 1'b1;
        @(negedge clk);
        get_result = 1'b0;
        check_value("phase after idle get_result", OP_BITS'(phase), OP_BITS'(PH_IDLE));
        check_value("result_word in idle", OP_BITS'(result_word), '0);
    endtask

    task automatic test_unit_exponent();
        operand_t got;
        run_case("e = 1", operand_t'(123456789), operand_t'(1), operand_t'(1000000007), got);
        check_value("e = 1 result against m", got, operand_t'(123456789));  // m below n
    endtask

    task automatic test_random_cases();
        operand_t n_val;
        operand_t m_val;
        operand_t e_val;
        operand_t got;
        for (int c = 0; c < 10; c++) begin
            n_val = random_modulus();
            m_val = random_base(n_val);
            e_val = random_operand();
            if (e_val == '0) begin
                e_val = operand_t'(1);
            end
            run_case($sformatf("random case %0d", c), m_val, e_val, n_val, got);
        end
    endtask

    // highest exponent one at several word positions, then a rerun without reset
    task automatic test_exponent_edges();
        operand_t n_val;
        operand_t m_val;
        operand_t e_val;
        operand_t first;
        operand_t second;
        n_val = random_modulus();
        m_val = random_base(n_val);
        e_val = '0;
        e_val[0] = 32'hc000_0005;
        run_case("top one in word 0", m_val, e_val, n_val, first);
        run_case("rerun without reset", m_val, e_val, n_val, second);
        check_value("rerun against first run", second, first);
        e_val = random_operand();
        for (int k = 2; k < NUM_WORDS; k++) begin
            e_val[k] = '0;
        end
        e_val[1] = 32'h0000_0001;                 // scan crosses into word 0
        run_case("top one at word 1 bit 0", m_val, e_val, n_val, first);
        e_val = random_operand();
        e_val[NUM_WORDS-1] = 32'h0000_8001;
        run_case("top one in top word", m_val, e_val, n_val, first);
        e_val = random_operand();
        e_val[NUM_WORDS-1] = e_val[NUM_WORDS-1] | 32'h8000_0000;
        run_case("top exponent bit", m_val, e_val, n_val, first);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        reset         = 1'b1;
        start_input   = 1'b0;
        start_compute = 1'b0;
        get_result    = 1'b0;
        load_words    = '0;
        nprime0       = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_idle_strobes();
        test_unit_exponent();
        test_random_cases();
        test_exponent_edges();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== rtl/exp_control.sv ====
/* left-to-right square-and-multiply over e, result read out one word per cycle
   e must be nonzero, otherwise the top bit scan never ends */
`timescale 1ns/1ps

module exp_control import modexp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_input,
    input  logic       start_compute,
    input  logic       get_result,
    input  logic       load_done,
    input  logic       mont_done,
    input  operand_t   m,
    input  operand_t   e,
    input  operand_t   r,
    input  operand_t   t,
    input  operand_t   product,
    output operand_t   a,
    output operand_t   b,
    output logic       mont_start,
    output exp_phase_t phase,
    output word_t      result_word,
    output logic       idle
);

    operand_t                        m_bar;
    operand_t                        c_bar;     // running result, Montgomery form
    logic [NUM_WORDS*WORD_WIDTH-1:0] e_flat;
    logic [BIT_IDX_WIDTH-1:0]        bit_idx;
    logic [WORD_IDX_WIDTH-1:0]       out_idx;

    assign e_flat      = e;
    assign idle        = (phase == PH_IDLE);
    assign result_word = (phase == PH_UNLOAD) ? c_bar[out_idx] : '0;

    // factor steering
    always_comb begin
        a = c_bar;
        b = c_bar;
        case (phase)
            PH_TO_MONT: begin
                a = m;
                b = t;
            end
            PH_MULTIPLY: begin
                b = m_bar;
            end
            PH_FROM_MONT: begin
                a = operand_t'(1);    // leaves the Montgomery domain
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= PH_IDLE;
            bit_idx    <= '0;
            out_idx    <= '0;
            mont_start <= 1'b0;
        end else begin
            mont_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start_input) begin
                        phase <= PH_LOAD;
                    end
                end
                PH_LOAD: begin
                    if (load_done) begin
                        phase <= PH_WAIT_COMPUTE;
                    end
                end
                PH_WAIT_COMPUTE: begin
                    if (start_compute) begin
                        phase      <= PH_TO_MONT;
                        mont_start <= 1'b1;
                    end
                end
                PH_TO_MONT: begin
                    if (mont_done) begin
                        phase   <= PH_FIND_TOP_BIT;
                        bit_idx <= BIT_IDX_WIDTH'(NUM_WORDS * WORD_WIDTH - 1);
                    end
                end
                PH_FIND_TOP_BIT: begin
                    if (e_flat[bit_idx]) begin
                        phase      <= PH_SQUARE;
                        mont_start <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;  // one bit per cycle
                    end
                end
                PH_SQUARE: begin
                    if (mont_done) begin
                        mont_start <= 1'b1;
                        if (e_flat[bit_idx]) begin
                            phase <= PH_MULTIPLY;
                        end else if (bit_idx == '0) begin
                            phase <= PH_FROM_MONT;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;  // square again
                        end
                    end
                end
                PH_MULTIPLY: begin
                    if (mont_done) begin
                        mont_start <= 1'b1;
                        if (bit_idx == '0) begin
                            phase <= PH_FROM_MONT;
                        end else begin
                            phase   <= PH_SQUARE;
                            bit_idx <= bit_idx - 1'b1;
                        end
                    end
                end
                PH_FROM_MONT: begin
                    if (mont_done) begin
                        phase <= PH_COMPLETE;
                    end
                end
                PH_COMPLETE: begin
                    if (get_result) begin
                        phase   <= PH_UNLOAD;
                        out_idx <= '0;
                    end
                end
                PH_UNLOAD: begin
                    out_idx <= out_idx + 1'b1;
                    if (out_idx == WORD_IDX_WIDTH'(NUM_WORDS - 1)) begin
                        phase <= PH_TERMINAL;
                    end
                end
                PH_TERMINAL: phase <= PH_IDLE;
                default:     phase <= PH_IDLE;
            endcase
        end
    end

    // product capture, c_bar starts as R mod n
    always_ff @(posedge clk) begin
        if (mont_done) begin
            if (phase == PH_TO_MONT) begin
                m_bar <= product;
                c_bar <= r;
            end else begin
                c_bar <= product;
            end
        end
    end

endmodule

// ==== rtl/modexp_pkg.sv ====
/* sizes and shared types for the Montgomery exponentiator
   n must stay below R/4 so the top two bits of the top word are zero */
package modexp_pkg;

    localparam int WORD_WIDTH     = 32;
    localparam int NUM_WORDS      = 4;                   // 128-bit modulus
    localparam int WORD_IDX_WIDTH = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam int BIT_IDX_WIDTH  = $clog2(NUM_WORDS * WORD_WIDTH);

    typedef logic [WORD_WIDTH-1:0] word_t;

    // least significant word at index 0
    typedef word_t [NUM_WORDS-1:0] operand_t;

    // one word position of every input operand
    typedef struct packed {
        word_t m;
        word_t e;
        word_t n;
        word_t r;   // R mod n
        word_t t;   // R^2 mod n
    } load_word_t;

    typedef enum logic [3:0] {
        PH_IDLE,
        PH_LOAD,
        PH_WAIT_COMPUTE,
        PH_TO_MONT,
        PH_FIND_TOP_BIT,
        PH_SQUARE,
        PH_MULTIPLY,
        PH_FROM_MONT,
        PH_COMPLETE,
        PH_UNLOAD,
        PH_TERMINAL
    } exp_phase_t;

endpackage

// ==== rtl/modexp_top.sv ====
/* m^e mod n by Montgomery exponentiation with plain strobes and no back-pressure
   needs odd n below R/4, 0 < m < n, nonzero e, nprime0 = -n^-1 mod 2^w held stable */
`timescale 1ns/1ps

module modexp_top import modexp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_input,
    input  logic       start_compute,
    input  logic       get_result,
    input  load_word_t load_words,
    input  word_t      nprime0,
    output exp_phase_t phase,
    output word_t      result_word
);

    operand_t m;
    operand_t e;
    operand_t n;
    operand_t r;
    operand_t t;
    operand_t a;
    operand_t b;
    operand_t product;
    logic     load_done;
    logic     idle;
    logic     mont_start;
    logic     mont_done;

    operand_store u_store (
        .clk         (clk),
        .reset       (reset),
        .start_input (start_input),
        .idle        (idle),
        .load_words  (load_words),
        .m           (m),
        .e           (e),
        .n           (n),
        .r           (r),
        .t           (t),
        .load_done   (load_done)
    );

    exp_control u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .load_done     (load_done),
        .mont_done     (mont_done),
        .m             (m),
        .e             (e),
        .r             (r),
        .t             (t),
        .product       (product),
        .a             (a),
        .b             (b),
        .mont_start    (mont_start),
        .phase         (phase),
        .result_word   (result_word),
        .idle          (idle)
    );

    mont_mult u_mont (
        .clk     (clk),
        .reset   (reset),
        .start   (mont_start),
        .a       (a),
        .b       (b),
        .n       (n),
        .nprime0 (nprime0),
        .product (product),
        .done    (mont_done)
    );

endmodule

// ==== rtl/mont_mult.sv ====
/* word-serial Montgomery product a*b*R^-1 mod n, no final subtraction
   start is taken only while idle; a, b, n and nprime0 must hold until done */
`timescale 1ns/1ps

module mont_mult import modexp_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    input  operand_t n,
    input  word_t    nprime0,
    output operand_t product,
    output logic     done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MUL,     // v += a[i] * b
        ST_FOLD,    // fold top carry into v[N], v[N+1]
        ST_RED,     // reduction factor
        ST_ADDN,    // v = (v + mfac * n) >> w
        ST_CARRY,   // v[N-1] = v[N] + c
        ST_TOP      // v[N] = v[N+1] + c
    } step_t;

    step_t                     step;
    logic                      capture;    // 0 issue cycle, 1 capture cycle
    logic [WORD_IDX_WIDTH-1:0] i_idx;
    logic [WORD_IDX_WIDTH-1:0] j_idx;
    word_t [NUM_WORDS+1:0]     v;          // partial vector
    word_t                     carry_r;
    word_t                     mfac;
    word_t                     mx;
    word_t                     my;
    word_t                     mz;
    word_t                     mc;
    word_t                     msum;
    word_t                     mcarry;

    mul_add u_mul_add (
        .clk      (clk),
        .x        (mx),
        .y        (my),
        .z        (mz),
        .carry_in (mc),
        .sum      (msum),
        .carry    (mcarry)
    );

    // multiplier operand select per step
    always_comb begin
        mx = '0;
        my = '0;
        mz = '0;
        mc = carry_r;
        case (step)
            ST_MUL: begin
                mx = a[i_idx];
                my = b[j_idx];
                mz = v[j_idx];
                if (j_idx == '0) begin
                    mc = '0;            // fresh carry chain
                end
            end
            ST_FOLD: begin
                mz = v[NUM_WORDS];
            end
            ST_RED: begin
                mx = v[0];
                my = nprime0;
                mc = '0;
            end
            ST_ADDN: begin
                mx = mfac;
                my = n[j_idx];
                mz = v[j_idx];
                if (j_idx == '0) begin
                    mc = '0;
                end
            end
            ST_CARRY: begin
                mz = v[NUM_WORDS];
            end
            ST_TOP: begin
                mz = v[NUM_WORDS+1];
            end
            default: begin
                mc = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step    <= ST_IDLE;
            capture <= 1'b0;
            i_idx   <= '0;
            j_idx   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (step == ST_IDLE) begin
                capture <= 1'b0;
                if (start) begin
                    step  <= ST_MUL;
                    i_idx <= '0;
                    j_idx <= '0;
                end
            end else if (!capture) begin
                capture <= 1'b1;
            end else begin
                capture <= 1'b0;
                case (step)
                    ST_MUL, ST_ADDN: begin
                        j_idx <= j_idx + 1'b1;
                        if (j_idx == WORD_IDX_WIDTH'(NUM_WORDS - 1)) begin
                            j_idx <= '0;
                            step  <= (step == ST_MUL) ? ST_FOLD : ST_CARRY;
                        end
                    end
                    ST_FOLD:  step <= ST_RED;
                    ST_RED:   step <= ST_ADDN;
                    ST_CARRY: step <= ST_TOP;
                    ST_TOP: begin
                        i_idx <= i_idx + 1'b1;
                        step  <= ST_MUL;
                        if (i_idx == WORD_IDX_WIDTH'(NUM_WORDS - 1)) begin
                            step <= ST_IDLE;
                            done <= 1'b1;   // product valid from here
                        end
                    end
                    default: step <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step == ST_IDLE && start) begin
            v       <= '0;
            carry_r <= '0;
            mfac    <= '0;
        end else if (capture) begin
            case (step)
                ST_MUL: begin
                    v[j_idx] <= msum;
                    carry_r  <= mcarry;
                end
                ST_FOLD: begin
                    v[NUM_WORDS]   <= msum;
                    v[NUM_WORDS+1] <= mcarry;
                end
                ST_RED: begin
                    mfac <= msum;           // only the low word matters
                end
                ST_ADDN: begin
                    if (j_idx != '0) begin
                        v[j_idx - 1'b1] <= msum;   // shift down one word
                    end
                    carry_r <= mcarry;
                end
                ST_CARRY: begin
                    v[NUM_WORDS-1] <= msum;
                    carry_r        <= mcarry;
                end
                ST_TOP: begin
                    v[NUM_WORDS] <= msum;
                end
                default: begin
                end
            endcase
        end
    end

    assign product = v[NUM_WORDS-1:0];

endmodule

// ==== rtl/mul_add.sv ====
/* registered x*y+z+carry_in, one cycle latency
   the full double-width result always fits, no overflow possible */
`timescale 1ns/1ps

module mul_add import modexp_pkg::*; (
    input  logic  clk,
    input  word_t x,
    input  word_t y,
    input  word_t z,
    input  word_t carry_in,
    output word_t sum,
    output word_t carry
);

    logic [2*WORD_WIDTH-1:0] acc;

    always_ff @(posedge clk) begin
        acc <= (2*WORD_WIDTH)'(x) * (2*WORD_WIDTH)'(y)
             + (2*WORD_WIDTH)'(z) + (2*WORD_WIDTH)'(carry_in);
    end

    assign sum   = acc[WORD_WIDTH-1:0];            // low word
    assign carry = acc[2*WORD_WIDTH-1:WORD_WIDTH]; // high word

endmodule

// ==== rtl/operand_store.sv ====
/* serial load of m, e, n, r and t, exactly NUM_WORDS words, low word first
   start_input is ignored unless the controller reports idle */
`timescale 1ns/1ps

module operand_store import modexp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_input,
    input  logic       idle,
    input  load_word_t load_words,
    output operand_t   m,
    output operand_t   e,
    output operand_t   n,
    output operand_t   r,
    output operand_t   t,
    output logic       load_done
);

    logic                      loading;
    logic [WORD_IDX_WIDTH-1:0] word_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loading   <= 1'b0;
            word_cnt  <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (!loading) begin
                if (start_input && idle) begin
                    loading  <= 1'b1;
                    word_cnt <= '0;
                end
            end else begin
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == WORD_IDX_WIDTH'(NUM_WORDS - 1)) begin
                    loading   <= 1'b0;
                    load_done <= 1'b1;  // one cycle after the last word
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loading) begin
            m[word_cnt] <= load_words.m;
            e[word_cnt] <= load_words.e;
            n[word_cnt] <= load_words.n;
            r[word_cnt] <= load_words.r;
            t[word_cnt] <= load_words.t;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f src.f --top-module modexp_tb -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/Vmodexp_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit "$sim_status"
fi

echo "simulation finished with status 0"
exit 0

// ==== src.f ====
+incdir+include
rtl/modexp_pkg.sv
rtl/mul_add.sv
rtl/mont_mult.sv
rtl/operand_store.sv
rtl/exp_control.sv
rtl/modexp_top.sv
dv/modexp_tb.sv
